// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// --------------------------------------------------------------------------
// Datapath and memory sizes
// --------------------------------------------------------------------------
`define RV_XLEN        32
`define RV_REG_COUNT   32
`define RV_IMEM_DEPTH  64
`define RV_DMEM_DEPTH  64

// --------------------------------------------------------------------------
// Major opcodes, funct codes
// --------------------------------------------------------------------------
`define RV_OPC_RTYPE   7'b0110011
`define RV_OPC_ITYPE   7'b0010011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_BRANCH  7'b1100011

// ADD, SUB and ADDI share funct3 000
`define RV_F3_ADD      3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_WORD     3'b010
`define RV_F3_XOR      3'b100
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111
`define RV_F3_BEQ      3'b000

`define RV_F7_BASE     7'b0000000
`define RV_F7_SUB      7'b0100000

// ADDI x0, x0, 0
`define RV_NOP         32'h0000_0013

`endif

// ==== source/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    // ----------------------------------------------------------------------
    // Widths with a meaning
    // ----------------------------------------------------------------------
    typedef logic [`RV_XLEN-1:0] word_t;                     // Data word or byte address
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;     // Register number
    typedef logic [$clog2(`RV_IMEM_DEPTH)-1:0] imem_idx_t;   // Instruction word index
    typedef logic [$clog2(`RV_DMEM_DEPTH)-1:0] dmem_idx_t;   // Data word index

    // ----------------------------------------------------------------------
    // Execute-stage operations
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll
    } alu_op_t;

    // What main control tells the ALU decoder
    typedef enum logic [1:0] {
        class_addr,     // Loads, stores, and the idle value
        class_branch,   // Compare by subtraction
        class_func      // Look at funct3 and funct7
    } alu_class_t;

endpackage

// ==== source/rv_if.sv ====
// ID/EX register contents, decode to execute
interface dex_if import rv_pkg::*; ();
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       alu_src;
    logic       branch;
    alu_class_t alu_class;
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_idx_t   rd;
    logic [2:0] funct3;
    logic [6:0] funct7;

    modport src (output reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch,
                 alu_class, pc, rs1_data, rs2_data, imm, rd, funct3, funct7);
    modport dst (input  reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch,
                 alu_class, pc, rs1_data, rs2_data, imm, rd, funct3, funct7);
endinterface

// EX/MEM register contents, execute to memory
interface dmem_if import rv_pkg::*; ();
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     branch;
    logic     zero;
    word_t    alu_result;
    word_t    store_data;
    word_t    branch_target;
    reg_idx_t rd;

    modport src (output reg_write, mem_read, mem_write, mem_to_reg, branch, zero,
                 alu_result, store_data, branch_target, rd);
    modport dst (input  reg_write, mem_read, mem_write, mem_to_reg, branch, zero,
                 alu_result, store_data, branch_target, rd);
endinterface

// ==== source/fetch_stage.sv ====
`include "rv_macros.svh"

module fetch_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  logic      load_valid,
    output logic      load_ready,
    input  imem_idx_t load_idx,
    input  word_t     load_data,
    input  logic      branch_taken,
    input  word_t     branch_target,
    output word_t     if_pc,
    output word_t     if_instr
);

    word_t     pc;
    word_t     pc_next;
    word_t     imem [`RV_IMEM_DEPTH];
    word_t     fetch_instr;
    imem_idx_t fetch_idx;
    logic      load_fire;

    // ----------------------------------------------------------------------
    // Program counter
    // ----------------------------------------------------------------------
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;    // Redirect wins even while parked
        end else if (run) begin
            pc_next = pc + 32'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // ----------------------------------------------------------------------
    // Instruction memory, filled over the load port
    // ----------------------------------------------------------------------
    assign load_ready = ~run;
    assign load_fire  = load_valid & load_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_IMEM_DEPTH; i++) begin
                imem[i] <= `RV_NOP;
            end
        end else if (load_fire) begin
            imem[load_idx] <= load_data;
        end
    end

    assign fetch_idx   = pc[$bits(imem_idx_t)+1:2];  // Word index
    assign fetch_instr = imem[fetch_idx];

    // IF/ID register, bubbles while parked
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_pc    <= '0;
            if_instr <= `RV_NOP;
        end else begin
            if_pc    <= pc;
            if_instr <= run ? fetch_instr : `RV_NOP;
        end
    end

endmodule

// ==== source/decode_stage.sv ====
`include "rv_macros.svh"

module decode_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    if_pc,
    input  word_t    if_instr,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    dex_if.src       dex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    logic       alu_src;
    logic       branch;
    alu_class_t alu_class;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      regs [`RV_REG_COUNT];

    // Instruction fields
    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    // ----------------------------------------------------------------------
    // Main control
    // ----------------------------------------------------------------------
    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        branch     = 1'b0;
        alu_class  = class_addr;
        case (opcode)
            `RV_OPC_RTYPE: begin
                reg_write = 1'b1;
                alu_class = class_func;
            end
            `RV_OPC_ITYPE: begin
                if (funct3 == `RV_F3_ADD) begin  // ADDI only, rest is a bubble
                    reg_write = 1'b1;
                    alu_src   = 1'b1;
                    alu_class = class_func;
                end
            end
            `RV_OPC_LOAD: begin
                if (funct3 == `RV_F3_WORD) begin
                    reg_write  = 1'b1;
                    mem_read   = 1'b1;
                    mem_to_reg = 1'b1;
                    alu_src    = 1'b1;
                end
            end
            `RV_OPC_STORE: begin
                if (funct3 == `RV_F3_WORD) begin
                    mem_write = 1'b1;
                    alu_src   = 1'b1;
                end
            end
            `RV_OPC_BRANCH: begin
                if (funct3 == `RV_F3_BEQ) begin
                    branch    = 1'b1;
                    alu_class = class_branch;
                end
            end
            default: ;  // Unknown opcode, all control stays low
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        case (opcode)
            `RV_OPC_ITYPE, `RV_OPC_LOAD:
                imm = {{20{if_instr[31]}}, if_instr[31:20]};
            `RV_OPC_STORE:
                imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            `RV_OPC_BRANCH:
                imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                       if_instr[30:25], if_instr[11:8], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Register file
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;     // x0 already filtered upstream
        end
    end

    // A write in this cycle is seen by the instruction being decoded
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    // ID/EX register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dex.reg_write  <= 1'b0;
            dex.mem_read   <= 1'b0;
            dex.mem_write  <= 1'b0;
            dex.mem_to_reg <= 1'b0;
            dex.alu_src    <= 1'b0;
            dex.branch     <= 1'b0;
            dex.alu_class  <= class_addr;
        end else begin
            dex.reg_write  <= reg_write;
            dex.mem_read   <= mem_read;
            dex.mem_write  <= mem_write;
            dex.mem_to_reg <= mem_to_reg;
            dex.alu_src    <= alu_src;
            dex.branch     <= branch;
            dex.alu_class  <= alu_class;
        end
    end

    always_ff @(posedge clk) begin
        dex.pc       <= if_pc;
        dex.rs1_data <= rs1_data;
        dex.rs2_data <= rs2_data;
        dex.imm      <= imm;
        dex.rd       <= rd;
        dex.funct3   <= funct3;
        dex.funct7   <= funct7;
    end

endmodule

// ==== source/execute_stage.sv ====
`include "rv_macros.svh"

module execute_stage import rv_pkg::*; (
    input logic clk,
    input logic rst,
    dex_if.dst  dex,
    dmem_if.src exm
);

    alu_op_t alu_op;
    word_t   op_b;
    word_t   alu_result;
    logic    zero;
    word_t   branch_target;

    // ----------------------------------------------------------------------
    // ALU control
    // ----------------------------------------------------------------------
    always_comb begin
        alu_op = alu_add;
        case (dex.alu_class)
            class_addr:   alu_op = alu_add;     // Load/store address
            class_branch: alu_op = alu_sub;     // BEQ compare
            class_func: begin
                if (dex.alu_src) begin
                    // I-type reaches here only as ADDI
                    if (dex.funct3 == `RV_F3_ADD) begin
                        alu_op = alu_add;
                    end
                end else begin
                    case ({dex.funct7, dex.funct3})
                        {`RV_F7_BASE, `RV_F3_ADD}: alu_op = alu_add;
                        {`RV_F7_SUB,  `RV_F3_ADD}: alu_op = alu_sub;
                        {`RV_F7_BASE, `RV_F3_AND}: alu_op = alu_and;
                        {`RV_F7_BASE, `RV_F3_OR}:  alu_op = alu_or;
                        {`RV_F7_BASE, `RV_F3_XOR}: alu_op = alu_xor;
                        {`RV_F7_BASE, `RV_F3_SLL}: alu_op = alu_sll;
                        default:                   alu_op = alu_add;
                    endcase
                end
            end
            default: alu_op = alu_add;
        endcase
    end

    // ALU and branch target
    assign op_b = dex.alu_src ? dex.imm : dex.rs2_data;

    always_comb begin
        case (alu_op)
            alu_add: alu_result = dex.rs1_data + op_b;
            alu_sub: alu_result = dex.rs1_data - op_b;
            alu_and: alu_result = dex.rs1_data & op_b;
            alu_or:  alu_result = dex.rs1_data | op_b;
            alu_xor: alu_result = dex.rs1_data ^ op_b;
            alu_sll: alu_result = dex.rs1_data << op_b[$clog2(`RV_XLEN)-1:0];
            default: alu_result = '0;
        endcase
    end

    assign zero          = (alu_result == '0);
    assign branch_target = dex.pc + dex.imm;    // PC of the BEQ itself

    // ----------------------------------------------------------------------
    // EX/MEM register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exm.reg_write  <= 1'b0;
            exm.mem_read   <= 1'b0;
            exm.mem_write  <= 1'b0;
            exm.mem_to_reg <= 1'b0;
            exm.branch     <= 1'b0;
            exm.zero       <= 1'b0;
        end else begin
            exm.reg_write  <= dex.reg_write;
            exm.mem_read   <= dex.mem_read;
            exm.mem_write  <= dex.mem_write;
            exm.mem_to_reg <= dex.mem_to_reg;
            exm.branch     <= dex.branch;
            exm.zero       <= zero;
        end
    end

    always_ff @(posedge clk) begin
        exm.alu_result    <= alu_result;
        exm.store_data    <= dex.rs2_data;
        exm.branch_target <= branch_target;
        exm.rd            <= dex.rd;
    end

endmodule

// ==== source/memory_stage.sv ====
`include "rv_macros.svh"

module memory_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    dmem_if.dst      exm,
    output logic     branch_taken,
    output word_t    branch_target,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     st_valid,
    output word_t    st_addr,
    output word_t    st_data
);

    word_t     dmem [`RV_DMEM_DEPTH];
    dmem_idx_t dmem_idx;
    word_t     load_data;
    logic      wb_reg_write;

    // ----------------------------------------------------------------------
    // Data memory
    // ----------------------------------------------------------------------
    assign dmem_idx = exm.alu_result[$bits(dmem_idx_t)+1:2];  // Word aligned

    always_ff @(posedge clk) begin
        if (exm.mem_write) begin
            dmem[dmem_idx] <= exm.store_data;
        end
    end

    assign load_data = exm.mem_read ? dmem[dmem_idx] : '0;

    // BEQ decision goes straight back to fetch
    assign branch_taken  = exm.branch & exm.zero;
    assign branch_target = exm.branch_target;

    // Store trace
    assign st_valid = exm.mem_write;
    assign st_addr  = exm.alu_result;
    assign st_data  = exm.store_data;

    // ----------------------------------------------------------------------
    // MEM/WB register and writeback
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= exm.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= exm.rd;
        wb_data <= exm.mem_to_reg ? load_data : exm.alu_result;
    end

    assign wb_en = wb_reg_write && (wb_rd != '0);  // Writes to x0 vanish here

endmodule

// ==== source/rv_core.sv ====
module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  logic      load_valid,
    output logic      load_ready,
    input  imem_idx_t load_idx,
    input  word_t     load_data,
    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output word_t     wb_data,
    output logic      st_valid,
    output word_t     st_addr,
    output word_t     st_data
);

    word_t if_pc;
    word_t if_instr;
    logic  branch_taken;
    word_t branch_target;

    dex_if  dex ();
    dmem_if exm ();

    fetch_stage u_fetch (
        .clk           (clk),
        .rst           (rst),
        .run           (run),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .load_idx      (load_idx),
        .load_data     (load_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .if_pc         (if_pc),
        .if_instr      (if_instr)
    );

    // Writeback path also serves as the wb trace
    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .wb_en    (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .dex      (dex.src)
    );

    execute_stage u_execute (
        .clk (clk),
        .rst (rst),
        .dex (dex.dst),
        .exm (exm.src)
    );

    memory_stage u_memory (
        .clk           (clk),
        .rst           (rst),
        .exm           (exm.dst),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_en         (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_data       (st_data)
    );

endmodule

// ==== sim/tb_top.sv ====
`include "rv_macros.svh"

module tb_top import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 400;

    logic      clk = 1'b0;
    logic      rst;
    logic      run;
    logic      load_valid;
    logic      load_ready;
    imem_idx_t load_idx;
    word_t     load_data;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    word_t     wb_data;
    logic      st_valid;
    word_t     st_addr;
    word_t     st_data;

    word_t     prog [$];
    word_t     stray_word;           // Offered while running and must be ignored
    reg_idx_t  exp_wb_rd [$];
    word_t     exp_wb_data [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];
    int        wb_errors    = 0;
    int        st_errors    = 0;
    int        other_errors = 0;
    int        wb_count     = 0;
    integer    seed         = 83;

    rv_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_idx   (load_idx),
        .load_data  (load_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    always #20 clk = ~clk;

    // ----------------------------------------------------------------------
    // Instruction encoders
    // ----------------------------------------------------------------------
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OPC_RTYPE};
    endfunction

    function automatic word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `RV_F3_WORD, imm[4:0], `RV_OPC_STORE};
    endfunction

    function automatic word_t b_type(input reg_idx_t rs1, input reg_idx_t rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, `RV_F3_BEQ, off[4:1], off[11],
                `RV_OPC_BRANCH};
    endfunction

    // At least three slots between producer and consumer and three delay slots per BEQ
    task automatic build_program();
        logic [11:0] r [6];
        foreach (r[i]) begin
            r[i] = 12'($random(seed));
        end
        r[0][11] = 1'b0;    // x1 positive
        r[1][11] = 1'b1;    // x2 negative so x1 != x2
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 1, 0, r[0]));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 2, 0, r[1]));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 3, 0, r[2]));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 4, 0, r[3]));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 12, 0, 12'h040));  // Store base
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_ADD, 5, 1, 2));           // 5
        prog.push_back(r_type(`RV_F7_SUB, `RV_F3_ADD, 6, 1, 3));
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_AND, 7, 2, 3));
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_OR, 8, 1, 4));
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_XOR, 9, 2, 4));
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_SLL, 10, 1, 4));          // 10
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 0, 1, 12'h007));   // Into x0
        prog.push_back(s_type(5, 12, 12'h008));
        prog.push_back(s_type(9, 12, 12'hffc));                             // Offset -4
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_ADD, 11, 0, 3));          // x0 as operand
        prog.push_back(i_type(`RV_OPC_LOAD, `RV_F3_WORD, 13, 12, 12'h008)); // 15
        prog.push_back(i_type(`RV_OPC_LOAD, `RV_F3_WORD, 14, 12, 12'hffc));
        prog.push_back(b_type(1, 1, 13'd24));                               // Taken to 23
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 15, 0, 12'h001));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 16, 0, 12'h002));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 17, 0, 12'h003));  // 20
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 18, 0, 12'h004));  // Skipped
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 19, 0, 12'h005));  // Skipped
        prog.push_back(b_type(1, 2, 13'd32));                               // Not taken
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 20, 14, 12'h001));
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_ADD, 21, 13, 5));         // 25
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 22, 0, r[4]));
        prog.push_back(i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 23, 20, r[5]));    // x20 just written
        prog.push_back(r_type(`RV_F7_BASE, `RV_F3_XOR, 24, 15, 21));        // x21 just written
        prog.push_back(b_type(0, 0, 13'd0));                                // Park here
        stray_word = i_type(`RV_OPC_ITYPE, `RV_F3_ADD, 23, 20, r[5] ^ 12'h001);
    endtask

    // ----------------------------------------------------------------------
    // Reference model in program order with delay slots
    // ----------------------------------------------------------------------
    task automatic run_model();
        word_t    xreg [32];
        word_t    dmem_model [word_t];
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        reg_idx_t rd;
        logic     write;
        logic     taken;
        logic     done;
        int       pc_idx;
        int       next_idx;
        int       target_idx;
        int       slots;
        int       steps;
        foreach (xreg[i]) begin
            xreg[i] = '0;
        end
        pc_idx     = 0;
        target_idx = 0;
        slots      = 0;
        steps      = 0;
        done       = 1'b0;
        while (!done && steps < 500) begin
            instr = (pc_idx < prog.size()) ? prog[pc_idx] : `RV_NOP;
            rd    = instr[11:7];
            a     = xreg[instr[19:15]];
            b     = xreg[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            write    = 1'b0;
            taken    = 1'b0;
            res      = '0;
            next_idx = pc_idx + 1;
            case (instr[6:0])
                `RV_OPC_RTYPE: begin
                    write = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        {`RV_F7_BASE, `RV_F3_ADD}: res = a + b;
                        {`RV_F7_SUB,  `RV_F3_ADD}: res = a - b;
                        {`RV_F7_BASE, `RV_F3_AND}: res = a & b;
                        {`RV_F7_BASE, `RV_F3_OR}:  res = a | b;
                        {`RV_F7_BASE, `RV_F3_XOR}: res = a ^ b;
                        {`RV_F7_BASE, `RV_F3_SLL}: res = a << b[4:0];
                        default:                   write = 1'b0;
                    endcase
                end
                `RV_OPC_ITYPE: begin
                    write = 1'b1;
                    res   = a + imm_i;
                end
                `RV_OPC_LOAD: begin
                    write = 1'b1;
                    res   = dmem_model[a + imm_i];
                end
                `RV_OPC_STORE: begin
                    exp_st_addr.push_back(a + imm_s);
                    exp_st_data.push_back(b);
                    dmem_model[a + imm_s] = b;
                end
                `RV_OPC_BRANCH: begin
                    taken = (a == b);
                    done  = taken && (imm_b == '0);  // Self loop ends the program
                end
                default: ;
            endcase
            if (slots > 0) begin
                slots--;
                if (slots == 0) begin
                    next_idx = target_idx;
                end
            end
            if (taken) begin
                target_idx = pc_idx + int'($signed(imm_b)) / 4;
                slots      = 3;
            end
            if (write && rd != 0) begin
                xreg[rd] = res;
                exp_wb_rd.push_back(rd);
                exp_wb_data.push_back(res);
            end
            pc_idx = next_idx;
            steps++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Checkers
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            assert (load_ready == !run) else begin
                $display("error load_ready: got 0x%0h, expected 0x%0h", load_ready, !run);
                other_errors++;
            end
        end
    end

    // Trace outputs change only at the rising edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            wb_count++;
            assert (exp_wb_rd.size() > 0) else begin
                $display("writeback to register %0d arrived with none expected", wb_rd);
                other_errors++;
            end
            if (exp_wb_rd.size() > 0) begin
                assert (wb_rd == exp_wb_rd[0]) else begin
                    $display("error wb_rd: got 0x%02h, expected 0x%02h", wb_rd, exp_wb_rd[0]);
                    wb_errors++;
                end
                assert (wb_data == exp_wb_data[0]) else begin
                    $display("error wb_data: got 0x%08h, expected 0x%08h",
                             wb_data, exp_wb_data[0]);
                    wb_errors++;
                end
                void'(exp_wb_rd.pop_front());
                void'(exp_wb_data.pop_front());
            end
        end
        if (!rst && st_valid) begin
            assert (exp_st_addr.size() > 0) else begin
                $display("store to address 0x%08h arrived with none expected", st_addr);
                other_errors++;
            end
            if (exp_st_addr.size() > 0) begin
                assert (st_addr == exp_st_addr[0]) else begin
                    $display("error st_addr: got 0x%08h, expected 0x%08h",
                             st_addr, exp_st_addr[0]);
                    st_errors++;
                end
                assert (st_data == exp_st_data[0]) else begin
                    $display("error st_data: got 0x%08h, expected 0x%08h",
                             st_data, exp_st_data[0]);
                    st_errors++;
                end
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    task automatic load_word(input imem_idx_t idx, input word_t data);
        int waited;
        @(negedge clk);
        load_valid = 1'b1;
        load_idx   = idx;
        load_data  = data;
        waited     = 0;
        @(posedge clk);
        while (!load_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!load_ready) begin
            $display("load port never became ready for word %0d", idx);
            other_errors++;
        end
    endtask

    task automatic wait_for_wb(input int n);
        int waited;
        waited = 0;
        while (wb_count < n && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (wb_count < n) begin
            $display("timed out after %0d writebacks, waiting for %0d", wb_count, n);
            other_errors++;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((exp_wb_rd.size() > 0 || exp_st_addr.size() > 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_wb_rd.size() > 0 || exp_st_addr.size() > 0) begin
            $display("program did not finish, %0d writebacks and %0d stores missing",
                     exp_wb_rd.size(), exp_st_addr.size());
            other_errors++;
        end
    endtask

    initial begin
        int edges;
        rst        = 1'b1;
        run        = 1'b0;
        load_valid = 1'b0;
        load_idx   = '0;
        load_data  = '0;
        build_program();
        run_model();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (prog[i]) begin
            load_word(imem_idx_t'(i), prog[i]);
        end
        @(negedge clk);
        load_valid = 1'b0;

        // First writeback shows in the cycle after the fourth edge
        @(negedge clk);
        run   = 1'b1;
        edges = 0;
        while (!wb_valid && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        if (!wb_valid) begin
            $display("no writeback appeared after run was raised");
            other_errors++;
        end else begin
            assert (edges == 4) else begin
                $display("error wb_valid latency: got 0x%0h edges, expected 0x4", edges);
                other_errors++;
            end
        end

        // Offer a word while running before slot 27 is fetched
        load_valid = 1'b1;
        load_idx   = 27;
        load_data  = stray_word;
        @(negedge clk);
        load_valid = 1'b0;

        // Pause well before the taken BEQ
        wait_for_wb(8);
        @(negedge clk);
        run = 1'b0;
        repeat (6) @(negedge clk);
        run = 1'b1;

        wait_for_drain();
        repeat (20) @(negedge clk);  // Extra beats would show up here
        @(posedge clk);
        $display("errors: writeback %0d, store %0d, other %0d",
                 wb_errors, st_errors, other_errors);
        if (wb_errors + st_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
source/rv_pkg.sv
source/rv_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core.sv
sim/tb_top.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - source/rv_pkg.sv
      - source/rv_if.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_top.sv
